// File: filelist.f
+incdir+logic
logic/cpuPkg.sv
logic/controlCore.sv
logic/execUnit.sv
logic/regBank.sv
logic/ioPort.sv
logic/cpuCore.sv
sim/cpuCore_tb.sv

// File: logic/controlCore.sv
`include "cpu_config.svh"

module controlCore (
        input  logic                 clk,
        input  logic                 rstN,
        input  cpuPkg::instrFields_t instr,
        input  logic                 instrValid,
        output cpuPkg::ctrlWord_t    ctrl,
        output logic                 commit,
        output logic                 halted
);

        logic haltReq;  // decoded halt

        assign commit = instrValid & ~halted;

        always_comb begin
                ctrl.aluOp   = cpuPkg::aluPassB;
                ctrl.shiftOp = cpuPkg::shNone;
                ctrl.useImm  = 1'b0;
                ctrl.wbSel   = cpuPkg::wbNone;
                ctrl.ioOp    = cpuPkg::ioNone;
                haltReq      = 1'b0;

                case (instr.opcode)
                        cpuPkg::opSlli: begin
                                ctrl.shiftOp = cpuPkg::shLeft;
                                ctrl.useImm  = 1'b1;
                                ctrl.wbSel   = cpuPkg::wbExec;
                        end
                        cpuPkg::opSrli: begin
                                ctrl.shiftOp = cpuPkg::shRightLogic;
                                ctrl.useImm  = 1'b1;
                                ctrl.wbSel   = cpuPkg::wbExec;
                        end
                        cpuPkg::opSrai: begin
                                ctrl.shiftOp = cpuPkg::shRightArith;
                                ctrl.useImm  = 1'b1;
                                ctrl.wbSel   = cpuPkg::wbExec;
                        end
                        cpuPkg::opAdd: begin
                                ctrl.aluOp = cpuPkg::aluAdd;
                                ctrl.wbSel = cpuPkg::wbExec;
                        end
                        cpuPkg::opSub: begin
                                ctrl.aluOp = cpuPkg::aluSub;
                                ctrl.wbSel = cpuPkg::wbExec;
                        end
                        cpuPkg::opAddi: begin
                                ctrl.aluOp  = cpuPkg::aluAdd;
                                ctrl.useImm = 1'b1;
                                ctrl.wbSel  = cpuPkg::wbExec;
                        end
                        cpuPkg::opSubi: begin
                                ctrl.aluOp  = cpuPkg::aluSub;
                                ctrl.useImm = 1'b1;
                                ctrl.wbSel  = cpuPkg::wbExec;
                        end
                        cpuPkg::opLi: begin
                                ctrl.useImm = 1'b1;     // pass the extended imm
                                ctrl.wbSel  = cpuPkg::wbExec;
                        end
                        cpuPkg::opAnd: begin
                                ctrl.aluOp = cpuPkg::aluAnd;
                                ctrl.wbSel = cpuPkg::wbExec;
                        end
                        cpuPkg::opOr: begin
                                ctrl.aluOp = cpuPkg::aluOr;
                                ctrl.wbSel = cpuPkg::wbExec;
                        end
                        cpuPkg::opSll: begin
                                ctrl.shiftOp = cpuPkg::shLeft;
                                ctrl.wbSel   = cpuPkg::wbExec;
                        end
                        cpuPkg::opSrl: begin
                                ctrl.shiftOp = cpuPkg::shRightLogic;
                                ctrl.wbSel   = cpuPkg::wbExec;
                        end
                        cpuPkg::opSra: begin
                                ctrl.shiftOp = cpuPkg::shRightArith;
                                ctrl.wbSel   = cpuPkg::wbExec;
                        end
                        cpuPkg::opXor: begin
                                ctrl.aluOp = cpuPkg::aluXor;
                                ctrl.wbSel = cpuPkg::wbExec;
                        end
                        cpuPkg::opNop: begin
                        end
                        cpuPkg::opOutSs:  ctrl.ioOp  = cpuPkg::ioSeg;
                        cpuPkg::opOutLed: ctrl.ioOp  = cpuPkg::ioLed;
                        cpuPkg::opInSw:   ctrl.wbSel = cpuPkg::wbSwitch;
                        cpuPkg::opHalt:   haltReq    = 1'b1;
                        cpuPkg::opRst: begin    // decodes like nop
                        end
                        default: begin          // retires as a no-op
                        end
                endcase
        end

        // sticky until reset
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN)
                        halted <= 1'b0;
                else if (commit && haltReq)
                        halted <= 1'b1;
        end

        knownInstrWhenValid: assert property (@(posedge clk) disable iff (!rstN)
                instrValid |-> !$isunknown(instr));

endmodule

// File: logic/cpuCore.sv
`include "cpu_config.svh"

module cpuCore (
        input  logic                      clk,
        input  logic                      rstN,
        input  cpuPkg::instrFields_t      instr,
        input  logic                      instrValid,
        input  logic [`CPU_DATA_W-1:0]    switches,
        output logic [`CPU_DATA_W-1:0]    led,
        output logic [`CPU_DATA_W-1:0]    seg,
        output logic                      halted
);

        cpuPkg::ctrlWord_t      ctrl;
        logic                   commit;
        logic [`CPU_DATA_W-1:0] rsData;
        logic [`CPU_DATA_W-1:0] rtData;
        logic [`CPU_DATA_W-1:0] rdData;
        logic [`CPU_DATA_W-1:0] execResult;
        logic [`CPU_DATA_W-1:0] swData;

        controlCore controlCore_i (
                .clk        (clk),
                .rstN       (rstN),
                .instr      (instr),
                .instrValid (instrValid),
                .ctrl       (ctrl),
                .commit     (commit),
                .halted     (halted)
        );

        execUnit execUnit_i (
                .ctrl       (ctrl),
                .rsData     (rsData),
                .rtData     (rtData),
                .rdData     (rdData),
                .imm        ({instr.rs, instr.rt}),    // imm overlaps rs and rt
                .execResult (execResult)
        );

        regBank regBank_i (
                .clk        (clk),
                .rstN       (rstN),
                .rdAddr     (instr.rd),
                .rsAddr     (instr.rs),
                .rtAddr     (instr.rt),
                .ctrl       (ctrl),
                .commit     (commit),
                .execResult (execResult),
                .swData     (swData),
                .rsData     (rsData),
                .rtData     (rtData),
                .rdData     (rdData)
        );

        ioPort ioPort_i (
                .clk      (clk),
                .rstN     (rstN),
                .ctrl     (ctrl),
                .commit   (commit),
                .rsData   (rsData),
                .switches (switches),
                .led      (led),
                .seg      (seg),
                .swData   (swData)
        );

endmodule

// File: logic/cpuPkg.sv
`include "cpu_config.svh"

package cpuPkg;

        // decoder ids that the core implements
        typedef enum logic [6:0] {
                opSlli   = 7'd1,
                opSrli   = 7'd2,
                opSrai   = 7'd3,
                opAdd    = 7'd4,
                opSub    = 7'd5,
                opAddi   = 7'd6,
                opSubi   = 7'd7,
                opLi     = 7'd8,
                opAnd    = 7'd12,
                opOr     = 7'd13,
                opSll    = 7'd14,
                opSrl    = 7'd15,
                opSra    = 7'd16,
                opXor    = 7'd18,
                opNop    = 7'd27,
                opOutSs  = 7'd69,
                opOutLed = 7'd70,
                opInSw   = 7'd71,
                opHalt   = 7'd75,
                opRst    = 7'd100
        } opcode_e;

        typedef enum logic [3:0] {aluPassB, aluAdd, aluSub, aluAnd, aluOr, aluXor} aluOp_e;

        typedef enum logic [2:0] {shNone, shLeft, shRightLogic, shRightArith} shiftOp_e;

        typedef enum logic [1:0] {wbNone, wbExec, wbSwitch} wbSel_e;

        typedef enum logic [1:0] {ioNone, ioLed, ioSeg} ioOp_e;

        typedef struct packed {
                logic [6:0]             opcode;
                logic [`CPU_REG_AW-1:0] rd;
                logic [`CPU_REG_AW-1:0] rs;     // imm high bits
                logic [`CPU_REG_AW-1:0] rt;     // imm low bits
        } instrFields_t;

        typedef struct packed {
                aluOp_e   aluOp;
                shiftOp_e shiftOp;
                logic     useImm;       // rd and imm instead of rs and rt
                wbSel_e   wbSel;
                ioOp_e    ioOp;
        } ctrlWord_t;

endpackage

// File: logic/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and instruction widths
`define CPU_DATA_W 16
`define CPU_INSTR_W 16

// register bank geometry
`define CPU_NUM_REGS 8
`define CPU_REG_AW 3

`endif

// File: logic/execUnit.sv
`include "cpu_config.svh"

module execUnit (
        input  cpuPkg::ctrlWord_t         ctrl,
        input  logic [`CPU_DATA_W-1:0]    rsData,
        input  logic [`CPU_DATA_W-1:0]    rtData,
        input  logic [`CPU_DATA_W-1:0]    rdData,
        input  logic [2*`CPU_REG_AW-1:0]  imm,
        output logic [`CPU_DATA_W-1:0]    execResult
);

        localparam int ImmW = 2 * `CPU_REG_AW;

        logic [`CPU_DATA_W-1:0] immExt;
        logic [`CPU_DATA_W-1:0] opA;
        logic [`CPU_DATA_W-1:0] opB;
        logic [3:0]             shAmt;
        logic [`CPU_DATA_W-1:0] aluResult;
        logic [`CPU_DATA_W-1:0] shiftResult;

        assign immExt = {{(`CPU_DATA_W - ImmW){imm[ImmW-1]}}, imm};

        // immediate forms work on rd in place
        assign opA   = ctrl.useImm ? rdData : rsData;
        assign opB   = ctrl.useImm ? immExt : rtData;
        assign shAmt = opB[3:0];

        always_comb begin
                case (ctrl.aluOp)
                        cpuPkg::aluAdd: aluResult = opA + opB;  // wraps
                        cpuPkg::aluSub: aluResult = opA - opB;
                        cpuPkg::aluAnd: aluResult = opA & opB;
                        cpuPkg::aluOr:  aluResult = opA | opB;
                        cpuPkg::aluXor: aluResult = opA ^ opB;
                        default:        aluResult = opB;
                endcase
        end

        always_comb begin
                case (ctrl.shiftOp)
                        cpuPkg::shLeft:       shiftResult = opA << shAmt;
                        cpuPkg::shRightLogic: shiftResult = opA >> shAmt;
                        cpuPkg::shRightArith: shiftResult = $signed(opA) >>> shAmt;
                        default:              shiftResult = opA;
                endcase
        end

        assign execResult = (ctrl.shiftOp != cpuPkg::shNone) ? shiftResult : aluResult;

        always_comb begin
                assert (!(ctrl.shiftOp != cpuPkg::shNone && ctrl.aluOp != cpuPkg::aluPassB))
                else $error("alu and shifter both selected");
        end

endmodule

// File: logic/ioPort.sv
`include "cpu_config.svh"

module ioPort (
        input  logic                      clk,
        input  logic                      rstN,
        input  cpuPkg::ctrlWord_t         ctrl,
        input  logic                      commit,
        input  logic [`CPU_DATA_W-1:0]    rsData,
        input  logic [`CPU_DATA_W-1:0]    switches,
        output logic [`CPU_DATA_W-1:0]    led,
        output logic [`CPU_DATA_W-1:0]    seg,
        output logic [`CPU_DATA_W-1:0]    swData
);

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        led <= '0;
                        seg <= '0;
                end else if (commit) begin
                        if (ctrl.ioOp == cpuPkg::ioLed)
                                led <= rsData;
                        if (ctrl.ioOp == cpuPkg::ioSeg)
                                seg <= rsData;  // raw value, no glyphs
                end
        end

        // one stage of sync on the switch pins
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN)
                        swData <= '0;
                else
                        swData <= switches;
        end

endmodule

// File: logic/regBank.sv
`include "cpu_config.svh"

module regBank (
        input  logic                      clk,
        input  logic                      rstN,
        input  logic [`CPU_REG_AW-1:0]    rdAddr,
        input  logic [`CPU_REG_AW-1:0]    rsAddr,
        input  logic [`CPU_REG_AW-1:0]    rtAddr,
        input  cpuPkg::ctrlWord_t         ctrl,
        input  logic                      commit,
        input  logic [`CPU_DATA_W-1:0]    execResult,
        input  logic [`CPU_DATA_W-1:0]    swData,
        output logic [`CPU_DATA_W-1:0]    rsData,
        output logic [`CPU_DATA_W-1:0]    rtData,
        output logic [`CPU_DATA_W-1:0]    rdData
);

        logic [`CPU_NUM_REGS-1:0][`CPU_DATA_W-1:0] regs;
        logic                                      wrEn;
        logic [`CPU_DATA_W-1:0]                    wrData;

        assign wrEn   = commit && (ctrl.wbSel != cpuPkg::wbNone);
        assign wrData = (ctrl.wbSel == cpuPkg::wbSwitch) ? swData : execResult;

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN)
                        regs <= '0;
                else if (wrEn)
                        regs[rdAddr] <= wrData;
        end

        assign rsData = regs[rsAddr];
        assign rtData = regs[rtAddr];
        assign rdData = regs[rdAddr];

        // the spare wbSel code would silently write execResult
        legalWbSel: assert property (@(posedge clk) disable iff (!rstN)
                commit |-> (ctrl.wbSel inside {cpuPkg::wbNone, cpuPkg::wbExec,
                        cpuPkg::wbSwitch}));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run from the project root, log to sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpuCore_tb -f filelist.f -o simv \
        && ./obj_dir/simv > sim.log 2>&1 \
        || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "failures reported in sim.log"; exit 1; }
echo "no failures reported in sim.log"
exit 0

// File: sim/cpuCore_tb.sv
`include "cpu_config.svh"

module cpuCore_tb;
        timeunit 1ns;
        timeprecision 100ps;

        typedef struct packed {
                int          testNum;
                logic [15:0] instr;
                logic [15:0] switches;
                logic [15:0] led;
                logic [15:0] seg;
                logic        halted;
        } traceEntry_t;

        logic                   clk;
        logic                   rstN;
        cpuPkg::instrFields_t   instr;
        logic                   instrValid;
        logic [`CPU_DATA_W-1:0] switches;
        logic [`CPU_DATA_W-1:0] led;
        logic [`CPU_DATA_W-1:0] seg;
        logic                   halted;

        traceEntry_t trace[$];
        logic [31:0] lcgState = 32'd57;
        logic        traceReady = 1'b0;
        int          errorCount = 0;
        int          checkCount = 0;
        int          testCount = 0;
        int          testErrors = 0;
        int          testChecks = 0;
        int          fd;

        cpuCore cpuCore_i (
                .clk        (clk),
                .rstN       (rstN),
                .instr      (instr),
                .instrValid (instrValid),
                .switches   (switches),
                .led        (led),
                .seg        (seg),
                .halted     (halted)
        );

        always #50 clk = ~clk;

        function automatic logic [31:0] lcgNext(input logic [31:0] state);
                return state * 32'd1103515245 + 32'd12345;
        endfunction

        task automatic loadTrace(input int fileId);
                string       line;
                int          lineNo;
                int          fields;
                int          tNum;
                logic [15:0] tInstr;
                logic [15:0] tSw;
                logic [15:0] tLed;
                logic [15:0] tSeg;
                logic [15:0] tHalt;
                traceEntry_t entry;
                lineNo = 0;
                while ($fgets(line, fileId) != 0) begin
                        lineNo++;
                        if (line.len() < 2 || line.substr(0, 0) == "#")
                                continue;       // blank or column notes
                        fields = $sscanf(line, "%d %h %h %h %h %h",
                                tNum, tInstr, tSw, tLed, tSeg, tHalt);
                        if (fields != 6) begin
                                $display("trace line %0d is malformed, six fields expected", lineNo);
                                errorCount++;
                        end else begin
                                entry = '{tNum, tInstr, tSw, tLed, tSeg, tHalt[0]};
                                trace.push_back(entry);
                        end
                end
                $fclose(fileId);
                if (trace.size() == 0) begin
                        $display("the trace holds no instructions");
                        errorCount++;
                end
        endtask

        task automatic checkValue(input string name, input logic [15:0] got,
                input logic [15:0] exp);
                checkCount++;
                testChecks++;
                assert (got === exp)
                else begin
                        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
                        errorCount++;
                        testErrors++;
                end
        endtask

        task automatic reportTest(input int num);
                $display("test %0d done: %0d checks, %0d errors", num, testChecks, testErrors);
                testCount++;
                testChecks = 0;
                testErrors = 0;
        endtask

        task automatic runTrace();
                logic [1:0] idleCycles;
                foreach (trace[i]) begin
                        if (i > 0 && trace[i].testNum != trace[i-1].testNum)
                                reportTest(trace[i-1].testNum);
                        @(posedge clk);
                        switches   <= trace[i].switches;  // stable before the instr edge
                        lcgState   = lcgNext(lcgState);
                        idleCycles = lcgState[17:16];
                        repeat (idleCycles) @(posedge clk);
                        @(posedge clk);
                        instr      <= trace[i].instr;
                        instrValid <= 1'b1;
                        @(posedge clk);                    // commit edge
                        instrValid <= 1'b0;
                        @(negedge clk);
                        checkValue("led", led, trace[i].led);
                        checkValue("seg", seg, trace[i].seg);
                        checkValue("halted", {15'b0, halted}, {15'b0, trace[i].halted});
                end
                if (trace.size() > 0)
                        reportTest(trace[trace.size()-1].testNum);
        endtask

        initial begin
                clk        = 1'b0;
                rstN       = 1'b0;
                instr      = '0;
                instrValid = 1'b0;
                switches   = '0;
                fd = $fopen("sim/cpu_trace.txt", "r");
                if (fd == 0) begin
                        $display("could not open the trace file sim/cpu_trace.txt");
                        $display("Simulation finished: FAIL");
                        $finish;
                end else begin
                        loadTrace(fd);
                        traceReady = 1'b1;
                        repeat (16) @(posedge clk);
                        rstN <= 1'b1;
                        runTrace();
                        $display("%0d tests, %0d checks, %0d errors",
                                testCount, checkCount, errorCount);
                        if (errorCount == 0)
                                $display("Simulation finished: PASS");
                        else
                                $display("Simulation finished: FAIL");
                        $finish;
                end
        end

        // six cycles per line at most, plus reset and slack
        initial begin : watchdog
                wait (traceReady);
                repeat (trace.size() * 6 + 16 + 4) @(posedge clk);
                $display("watchdog timeout, the trace did not finish in time");
                $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

// File: sim/cpu_trace.txt
# test instr switches led seg halted, all but the test number in hex
# led, seg and halted are the values expected after the instruction commits
1 3600 0000 0000 0000 0
1 1045 0000 0000 0000 0
1 10BD 0000 0000 0000 0
1 8C08 0000 0005 0000 0
1 8A10 0000 0005 FFFD 0
2 08CA 0000 0005 FFFD 0
2 0B0A 0000 0005 FFFD 0
2 0D1F 0000 0005 FFFD 0
2 0F20 0000 0005 FFFD 0
2 1962 0000 0005 FFFD 0
2 1B8B 0000 0005 FFFD 0
2 25D4 0000 0005 FFFD 0
2 8C20 0000 0047 FFFD 0
2 8A28 0000 0047 0045 0
2 8C30 0000 0007 0045 0
2 8A38 0000 0007 FFBA 0
3 07C2 0000 0007 FFBA 0
3 048F 0000 0007 FFBA 0
3 0243 0000 0007 FFBA 0
3 1CCA 0000 0007 FFBA 0
3 1FBB 0000 0007 FFBA 0
3 217A 0000 0007 FFBA 0
3 8C18 0000 0050 FFBA 0
3 8A30 0000 0050 FFEE 0
3 8C28 0000 FFF7 FFEE 0
4 8F00 A5C3 FFF7 FFEE 0
4 8A20 3C5A FFF7 A5C3 0
5 5123 0000 FFF7 A5C3 0
5 373F 0000 FFF7 A5C3 0
5 C921 0000 FFF7 A5C3 0
5 8C20 0000 A5C3 A5C3 0
6 9600 0000 A5C3 A5C3 1
6 8C08 0000 A5C3 A5C3 1
6 8A30 0000 A5C3 A5C3 1
